/* Makefile */
# Verilator build and run of the rename and retire testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= rob_retire.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass text shows up in the output
run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* dispatch_limiter.sv */
// acceptance logic for one dispatch group
// takes the longest valid prefix that fits both ROB room and free physical tags
`timescale 1ns/1ps

module dispatch_limiter #(
    parameter int N         = 2,
    parameter int ROB_DEPTH = 8
) (
    input  rob_pkg::dispatch_slot_t [N-1:0]       dispatch,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]        open_entries,
    input  rob_pkg::free_count_t                  free_count,
    output logic [$clog2(N+1)-1:0]                accept_count,
    output logic [N-1:0]                          dest_mask
);
    localparam int CNT_W = $clog2(N+1);

    // running count of writers in slots 0..i
    logic [CNT_W-1:0] writers;
    // set once a slot fails, later slots cannot be taken out of order
    logic             blocked;

    always_comb begin
        accept_count = '0;
        writers      = '0;
        blocked      = 1'b0;
        for (int i = 0; i < N; i++) begin
            // destination need by class, the only place this is decided
            dest_mask[i] = dispatch[i].valid &&
                           ((dispatch[i].inst_class == rob_pkg::ALU) ||
                            (dispatch[i].inst_class == rob_pkg::LOAD));
            writers = writers + CNT_W'(dest_mask[i]);

            // room includes entries retiring this cycle
            // free tags exclude those reclaimed this cycle
            if (!blocked && dispatch[i].valid &&
                ((i + 1) <= int'(open_entries)) &&
                (int'(writers) <= int'(free_count))) begin
                accept_count = CNT_W'(i + 1);
            end else begin
                blocked = 1'b1;
            end
        end
    end

endmodule

/* free_list.sv */
// circular queue of free physical tags
// pops one tag per accepted writer and reclaims told of each retiring writer
`timescale 1ns/1ps

module free_list #(
    parameter int N = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [N-1:0]                      dest_mask,
    input  logic [$clog2(N+1)-1:0]            accept_count,
    input  rob_pkg::retire_slot_t [N-1:0]     retire,
    output rob_pkg::phys_tag_t [N-1:0]        alloc_tag,
    output rob_pkg::free_count_t              free_count
);
    localparam int PTR_W = $clog2(rob_pkg::FREE_REGS);
    localparam int CNT_W = $clog2(N+1);

    typedef logic [PTR_W-1:0] ptr_t;

    // queue length is not a power of two so pointers wrap by compare
    function automatic ptr_t wrap_add(input ptr_t base, input int unsigned off);
        int unsigned sum;
        sum = int'(base) + off;
        if (sum >= rob_pkg::FREE_REGS) begin
            sum = sum - rob_pkg::FREE_REGS;
        end
        return ptr_t'(sum);
    endfunction

    rob_pkg::phys_tag_t queue [rob_pkg::FREE_REGS];

    ptr_t                 head;
    ptr_t                 tail;
    rob_pkg::free_count_t count;

    logic [CNT_W-1:0] pop_count;
    logic [CNT_W-1:0] push_count;
    logic [N-1:0]     push_en;
    ptr_t [N-1:0]     push_idx;

    // k-th lane is the k-th tag from head, handed to the k-th writer
    always_comb begin
        for (int k = 0; k < N; k++) begin
            alloc_tag[k] = queue[wrap_add(head, k)];
        end
    end

    // pops only for writers inside the accepted prefix
    always_comb begin
        pop_count = '0;
        for (int i = 0; i < N; i++) begin
            if ((i < int'(accept_count)) && dest_mask[i]) begin
                pop_count = pop_count + 1'b1;
            end
        end
    end

    // retiring writers pushed packed at tail in retirement order
    always_comb begin
        push_count = '0;
        for (int j = 0; j < N; j++) begin
            push_en[j]  = retire[j].valid && retire[j].has_dest;
            push_idx[j] = wrap_add(tail, push_count);
            if (push_en[j]) begin
                push_count = push_count + 1'b1;
            end
        end
    end

    // reclaimed tags show up in free_count only after the edge
    assign free_count = count;

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= rob_pkg::free_count_t'(rob_pkg::FREE_REGS);
            // tags above the reset map, ascending
            for (int i = 0; i < rob_pkg::FREE_REGS; i++) begin
                queue[i] <= rob_pkg::phys_tag_t'(rob_pkg::ARCH_REGS + i);
            end
        end else begin
            head  <= wrap_add(head, pop_count);
            tail  <= wrap_add(tail, push_count);
            count <= count - pop_count + push_count;
            for (int j = 0; j < N; j++) begin
                if (push_en[j]) begin
                    queue[push_idx[j]] <= retire[j].told;
                end
            end
        end
    end

endmodule

/* rename_map.sv */
// speculative map table from architectural register to physical tag
// gives each accepted writer its told and slot tag, with bypass inside one group
`timescale 1ns/1ps

module rename_map #(
    parameter int N = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  rob_pkg::dispatch_slot_t [N-1:0]   dispatch,
    input  logic [N-1:0]                      dest_mask,
    input  logic [$clog2(N+1)-1:0]            accept_count,
    input  rob_pkg::phys_tag_t [N-1:0]        alloc_tag,
    output rob_pkg::phys_tag_t [N-1:0]        told,
    output rob_pkg::phys_tag_t [N-1:0]        slot_tag
);
    rob_pkg::phys_tag_t map      [rob_pkg::ARCH_REGS];
    rob_pkg::phys_tag_t next_map [rob_pkg::ARCH_REGS];

    // walk slots oldest first so a later slot sees an earlier one's mapping
    always_comb begin
        int unsigned lane;
        lane     = 0;
        next_map = map;
        for (int i = 0; i < N; i++) begin
            told[i]     = '0;
            slot_tag[i] = '0;
            if ((i < int'(accept_count)) && dest_mask[i]) begin
                told[i]     = next_map[dispatch[i].arch_dest];
                // free list lanes are packed by writer, not by slot
                slot_tag[i] = alloc_tag[lane];
                next_map[dispatch[i].arch_dest] = alloc_tag[lane];
                lane = lane + 1;
            end
        end
    end

    // last write to a register within the group wins
    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping, arch i in phys i
            for (int r = 0; r < rob_pkg::ARCH_REGS; r++) begin
                map[r] <= rob_pkg::phys_tag_t'(r);
            end
        end else begin
            map <= next_map;
        end
    end

endmodule

/* rob.sv */
// N-way reorder buffer
// appends accepted entries at tail, marks completions by tag, retires in order from head
`timescale 1ns/1ps

module rob #(
    parameter int N         = 2,
    // must be a power of two, pointers wrap by truncation
    parameter int ROB_DEPTH = 8
) (
    input  logic                              clock,
    input  logic                              reset,
    input  rob_pkg::rob_entry_t [N-1:0]       wr_data,
    input  logic [$clog2(N+1)-1:0]            accept_count,
    input  rob_pkg::complete_slot_t [N-1:0]   complete,
    output rob_pkg::retire_slot_t [N-1:0]     retire,
    output logic [$clog2(N+1)-1:0]            retire_count,
    output logic [$clog2(ROB_DEPTH+1)-1:0]    open_entries
);
    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int OCC_W = $clog2(ROB_DEPTH+1);

    typedef logic [PTR_W-1:0] ptr_t;

    // head is the oldest entry, tail one past the youngest
    ptr_t             head;
    ptr_t             tail;
    logic [OCC_W-1:0] count;

    rob_pkg::rob_entry_t [ROB_DEPTH-1:0] entries;
    rob_pkg::rob_entry_t [ROB_DEPTH-1:0] next_entries;

    // index of the i-th entry from head
    ptr_t [N-1:0] ret_idx;
    // cleared at the first entry that cannot retire
    logic         in_order;

    // retirement from head, stops at the first incomplete or empty entry
    always_comb begin
        retire_count = '0;
        in_order     = 1'b1;
        for (int i = 0; i < N; i++) begin
            ret_idx[i] = head + ptr_t'(i);
            retire[i]  = '0;
            if (in_order && entries[ret_idx[i]].valid && entries[ret_idx[i]].complete) begin
                retire[i].valid     = 1'b1;
                retire[i].has_dest  = entries[ret_idx[i]].has_dest;
                retire[i].arch_dest = entries[ret_idx[i]].arch_dest;
                retire[i].t         = entries[ret_idx[i]].t;
                retire[i].told      = entries[ret_idx[i]].told;
                retire_count        = retire_count + 1'b1;
            end else begin
                in_order = 1'b0;
            end
        end
    end

    // retiring entries already count as open, so a full ROB
    // can take new work in the same cycle that it drains
    assign open_entries = OCC_W'(ROB_DEPTH) - count + OCC_W'(retire_count);

    always_comb begin
        next_entries = entries;

        // completion broadcasts, matched only on entries that own a tag
        for (int j = 0; j < N; j++) begin
            for (int k = 0; k < ROB_DEPTH; k++) begin
                if (complete[j].valid && entries[k].valid && entries[k].has_dest &&
                    (entries[k].t == complete[j].tag)) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end

        // free retired slots before the append, tail may land on them
        for (int i = 0; i < N; i++) begin
            if (i < int'(retire_count)) begin
                next_entries[ret_idx[i]] = '0;
            end
        end

        // append the accepted prefix at tail
        for (int i = 0; i < N; i++) begin
            if (i < int'(accept_count)) begin
                next_entries[tail + ptr_t'(i)] = wr_data[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            // every entry starts empty and incomplete
            for (int k = 0; k < ROB_DEPTH; k++) begin
                entries[k].valid    <= 1'b0;
                entries[k].complete <= 1'b0;
            end
        end else begin
            head    <= head + ptr_t'(retire_count);
            tail    <= tail + ptr_t'(accept_count);
            count   <= count - OCC_W'(retire_count) + OCC_W'(accept_count);
            entries <= next_entries;
        end
    end

endmodule

/* rob_pkg.sv */
// shared types for the rename and retire subsystem
// register counts, tag widths, instruction classes and the packed lanes between blocks
package rob_pkg;

    // architectural and physical register file sizes
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 32;

    // tags not held by the reset map start out on the free list
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

    // free list occupancy, 0 up to FREE_REGS inclusive
    typedef logic [$clog2(FREE_REGS+1)-1:0] free_count_t;

    // only ALU and LOAD produce a register result
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        LOAD   = 2'd1,
        STORE  = 2'd2,
        BRANCH = 2'd3
    } inst_class_e;

    // one dispatch lane, slot 0 is the oldest
    typedef struct packed {
        logic        valid;
        inst_class_e inst_class;
        arch_reg_t   arch_dest;
    } dispatch_slot_t;

    // one completion broadcast from a functional unit
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } complete_slot_t;

    // reorder buffer entry, t is the new tag and told the mapping it replaced
    typedef struct packed {
        logic        valid;
        logic        complete;
        logic        has_dest;
        inst_class_e inst_class;
        arch_reg_t   arch_dest;
        phys_tag_t   t;
        phys_tag_t   told;
    } rob_entry_t;

    // retirement packet for the architectural map and the free list
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_tag_t t;
        phys_tag_t told;
    } retire_slot_t;

endpackage

/* rob_properties.sv */
// concurrent checks on ROB occupancy and retirement order
// bound into every rob instance by the bind at the bottom
`timescale 1ns/1ps

module rob_properties #(
    parameter int N         = 2,
    parameter int ROB_DEPTH = 8
) (
    input logic                                 clock,
    input logic                                 reset,
    input logic [$clog2(ROB_DEPTH)-1:0]         head,
    input logic [$clog2(ROB_DEPTH+1)-1:0]       count,
    input rob_pkg::rob_entry_t [ROB_DEPTH-1:0]  entries,
    input rob_pkg::retire_slot_t [N-1:0]        retire,
    input logic [$clog2(ROB_DEPTH+1)-1:0]       open_entries
);
    localparam int OCC_W = $clog2(ROB_DEPTH+1);

    logic [N-1:0] retire_valid;

    // number of failed properties so far
    int failures = 0;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            retire_valid[i] = retire[i].valid;
        end
    end

    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        count <= OCC_W'(ROB_DEPTH))
        else begin
            failures++;
            $error("rob holds %0d entries, more than its depth", count);
        end

    // a run of ones from lane 0 has no set bit above a clear one
    retire_contiguous: assert property (@(posedge clock) disable iff (reset)
        (retire_valid & (retire_valid + N'(1))) == '0)
        else begin
            failures++;
            $error("retire valids not contiguous from lane 0: %b", retire_valid);
        end

    // lane 0 retires the entry at head as it stood before the edge
    retire_from_head: assert property (@(posedge clock) disable iff (reset)
        retire[0].valid |-> (entries[head].valid && entries[head].complete &&
                             (retire[0].t == entries[head].t) &&
                             (retire[0].told == entries[head].told)))
        else begin
            failures++;
            $error("lane 0 retired something other than a complete head entry");
        end

    open_bound: assert property (@(posedge clock) disable iff (reset)
        open_entries <= OCC_W'(ROB_DEPTH))
        else begin
            failures++;
            $error("open_entries %0d above depth", open_entries);
        end

endmodule

bind rob rob_properties #(.N(N), .ROB_DEPTH(ROB_DEPTH)) props0 (
    .clock(clock), .reset(reset), .head(head), .count(count), .entries(entries),
    .retire(retire), .open_entries(open_entries)
);

/* rob_retire.f */
rob_pkg.sv
dispatch_limiter.sv
free_list.sv
rename_map.sv
rob.sv
rob_retire_top.sv
rob_properties.sv
rob_tb.sv

/* rob_retire_top.sv */
// rename and retire subsystem around an N-way reorder buffer
// dispatch slots in, tags and retirement packets out, counts as the only handshake
`timescale 1ns/1ps

module rob_retire_top #(
    parameter int N         = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                              clock,
    input  logic                              reset,
    input  rob_pkg::dispatch_slot_t [N-1:0]   dispatch,
    input  rob_pkg::complete_slot_t [N-1:0]   complete,
    output logic [$clog2(N+1)-1:0]            accept_count,
    output rob_pkg::phys_tag_t [N-1:0]        dispatch_tag,
    output rob_pkg::retire_slot_t [N-1:0]     retire,
    output logic [$clog2(N+1)-1:0]            retire_count,
    output logic [$clog2(ROB_DEPTH+1)-1:0]    open_entries
);
    logic [N-1:0]                dest_mask;
    rob_pkg::free_count_t        free_count;
    rob_pkg::phys_tag_t [N-1:0]  alloc_tag;
    rob_pkg::phys_tag_t [N-1:0]  told;
    rob_pkg::rob_entry_t [N-1:0] wr_data;

    dispatch_limiter #(.N(N), .ROB_DEPTH(ROB_DEPTH)) limiter0 (
        .dispatch(dispatch), .open_entries(open_entries), .free_count(free_count),
        .accept_count(accept_count), .dest_mask(dest_mask)
    );

    free_list #(.N(N)) free_list0 (
        .clock(clock), .reset(reset), .dest_mask(dest_mask), .accept_count(accept_count),
        .retire(retire), .alloc_tag(alloc_tag), .free_count(free_count)
    );

    rename_map #(.N(N)) map0 (
        .clock(clock), .reset(reset), .dispatch(dispatch), .dest_mask(dest_mask),
        .accept_count(accept_count), .alloc_tag(alloc_tag),
        .told(told), .slot_tag(dispatch_tag)
    );

    // entry lanes, stores and branches own no tag and enter already complete
    always_comb begin
        for (int i = 0; i < N; i++) begin
            wr_data[i].valid      = dispatch[i].valid;
            wr_data[i].complete   = ~dest_mask[i];
            wr_data[i].has_dest   = dest_mask[i];
            wr_data[i].inst_class = dispatch[i].inst_class;
            wr_data[i].arch_dest  = dispatch[i].arch_dest;
            wr_data[i].t          = dispatch_tag[i];
            wr_data[i].told       = told[i];
        end
    end

    rob #(.N(N), .ROB_DEPTH(ROB_DEPTH)) rob0 (
        .clock(clock), .reset(reset), .wr_data(wr_data), .accept_count(accept_count),
        .complete(complete), .retire(retire), .retire_count(retire_count),
        .open_entries(open_entries)
    );

endmodule

/* rob_tb.sv */
// testbench for the rename and retire subsystem
// stimulus table per cycle, checked against a reference model of renaming and retirement
`timescale 1ns/1ps

module rob_tb;
    localparam int N            = 2;
    localparam int ROB_DEPTH    = 8;
    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 18;
    localparam int FIXED_ROWS   = 17;
    localparam int RANDOM_ROWS  = 24;
    localparam int DRAIN_ROWS   = 12;
    localparam int NUM_ROWS     = FIXED_ROWS + RANDOM_ROWS + DRAIN_ROWS;
    // completion codes, 0 or more names the k-th tagged dispatch
    localparam int NONE = -1;
    localparam int RAND = -2;
    // expected count left to the model
    localparam int SKIP = -1;

    typedef struct packed {
        rob_pkg::dispatch_slot_t [N-1:0] slots;
        int                              comp0;
        int                              comp1;
        int                              exp_accept;
        int                              exp_retire;
    } row_t;

    typedef struct packed {
        logic               has_dest;
        logic               complete;
        rob_pkg::arch_reg_t arch_dest;
        rob_pkg::phys_tag_t t;
        rob_pkg::phys_tag_t told;
    } model_entry_t;

    logic                               clock = 1'b0;
    logic                               reset = 1'b1;
    rob_pkg::dispatch_slot_t [N-1:0]    dispatch = '0;
    rob_pkg::complete_slot_t [N-1:0]    complete = '0;
    logic [$clog2(N+1)-1:0]             accept_count;
    rob_pkg::phys_tag_t [N-1:0]         dispatch_tag;
    rob_pkg::retire_slot_t [N-1:0]      retire;
    logic [$clog2(N+1)-1:0]             retire_count;
    logic [$clog2(ROB_DEPTH+1)-1:0]     open_entries;

    // reference state, oldest first in every queue
    row_t               table_q [$];
    model_entry_t       rob_q [$];
    rob_pkg::phys_tag_t free_q [$];
    rob_pkg::phys_tag_t map_q [rob_pkg::ARCH_REGS];
    rob_pkg::phys_tag_t writer_tag [$];
    int                 checks = 0;
    int                 errors = 0;
    int                 row_idx = 0;

    always #(PERIOD/2) clock = ~clock;

    rob_retire_top #(.N(N), .ROB_DEPTH(ROB_DEPTH)) dut0 (
        .clock(clock), .reset(reset), .dispatch(dispatch), .complete(complete),
        .accept_count(accept_count), .dispatch_tag(dispatch_tag), .retire(retire),
        .retire_count(retire_count), .open_entries(open_entries)
    );

    function automatic rob_pkg::dispatch_slot_t make_slot(input rob_pkg::inst_class_e cls,
                                                          input int r);
        rob_pkg::dispatch_slot_t s;
        s.valid      = 1'b1;
        s.inst_class = cls;
        s.arch_dest  = rob_pkg::arch_reg_t'(r);
        return s;
    endfunction

    // only ALU and LOAD produce a register
    function automatic logic writes_dest(input rob_pkg::dispatch_slot_t s);
        return s.valid && (s.inst_class == rob_pkg::ALU || s.inst_class == rob_pkg::LOAD);
    endfunction

    // first k slots present, room for k, and a free tag for each writer among them
    function automatic logic prefix_fits(input rob_pkg::dispatch_slot_t [N-1:0] slots,
                                         input int k, input int room);
        int need;
        need = 0;
        for (int i = 0; i < k; i++) begin
            if (!slots[i].valid) begin
                return 1'b0;
            end
            need += int'(writes_dest(slots[i]));
        end
        return (k <= room) && (need <= free_q.size());
    endfunction

    task automatic add_row(input rob_pkg::dispatch_slot_t s0, input rob_pkg::dispatch_slot_t s1,
                           input int c0, input int c1, input int ea, input int er);
        row_t row;
        row.slots[0]   = s0;
        row.slots[1]   = s1;
        row.comp0      = c0;
        row.comp1      = c1;
        row.exp_accept = ea;
        row.exp_retire = er;
        table_q.push_back(row);
    endtask

    task automatic build_table();
        rob_pkg::dispatch_slot_t idle;
        idle = '0;
        // first tags 8 up, second write to r1 in one group sees the first
        add_row(make_slot(rob_pkg::ALU, 1), make_slot(rob_pkg::ALU, 1), NONE, NONE, 2, 0);
        add_row(make_slot(rob_pkg::STORE, 0), make_slot(rob_pkg::LOAD, 2), NONE, NONE, 2, 0);
        add_row(make_slot(rob_pkg::BRANCH, 0), make_slot(rob_pkg::ALU, 3), NONE, NONE, 2, 0);
        // younger ones finish first, nothing leaves until the oldest does
        add_row(idle, idle, 1, 2, 0, 0);
        add_row(idle, idle, 0, NONE, 0, 0);
        add_row(idle, idle, NONE, NONE, 0, 2);
        add_row(idle, idle, NONE, NONE, 0, 2);
        // branch retires, stops at the incomplete r3 writer
        add_row(idle, idle, NONE, NONE, 0, 1);
        add_row(make_slot(rob_pkg::ALU, 4), make_slot(rob_pkg::ALU, 5), 3, NONE, 2, 0);
        add_row(make_slot(rob_pkg::ALU, 6), make_slot(rob_pkg::ALU, 7), NONE, NONE, 2, 1);
        add_row(make_slot(rob_pkg::ALU, 0), make_slot(rob_pkg::ALU, 1), NONE, NONE, 2, 0);
        add_row(make_slot(rob_pkg::ALU, 2), make_slot(rob_pkg::ALU, 3), NONE, NONE, 2, 0);
        // full ROB, room opens only in the cycle that retires
        add_row(make_slot(rob_pkg::ALU, 4), make_slot(rob_pkg::ALU, 5), NONE, NONE, 0, 0);
        add_row(make_slot(rob_pkg::ALU, 4), make_slot(rob_pkg::ALU, 5), 4, 5, 0, 0);
        add_row(make_slot(rob_pkg::ALU, 4), make_slot(rob_pkg::ALU, 5), NONE, NONE, 2, 2);
        add_row(make_slot(rob_pkg::STORE, 0), make_slot(rob_pkg::ALU, 6), 6, NONE, 0, 0);
        add_row(make_slot(rob_pkg::STORE, 0), make_slot(rob_pkg::ALU, 6), NONE, NONE, 1, 1);
        // steady traffic wraps the free queue onto reclaimed told tags
        // 24 free tags over 8 entries never run short here, the model still bounds by them
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            add_row(make_slot((i % 5 == 4) ? rob_pkg::STORE : rob_pkg::ALU, i % 8),
                    make_slot(rob_pkg::LOAD, (i + 3) % 8), RAND, RAND, SKIP, SKIP);
        end
        for (int i = 0; i < DRAIN_ROWS; i++) begin
            add_row(idle, idle, RAND, RAND, SKIP, SKIP);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: row %0d %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    // one tag among writers still waiting on their functional unit
    task automatic pick_outstanding(output logic found, output rob_pkg::phys_tag_t tag);
        rob_pkg::phys_tag_t waiting [$];
        foreach (rob_q[k]) begin
            if (rob_q[k].has_dest && !rob_q[k].complete) begin
                waiting.push_back(rob_q[k].t);
            end
        end
        found = (waiting.size() > 0);
        tag   = found ? waiting[$urandom % waiting.size()] : '0;
    endtask

    task automatic apply_row(input row_t row);
        rob_pkg::complete_slot_t [N-1:0] comp;
        rob_pkg::phys_tag_t              reclaim [$];
        model_entry_t                    entry;
        int                              code;
        int                              nret;
        int                              room;
        int                              acc;
        comp = '0;
        for (int l = 0; l < N; l++) begin
            code = (l == 0) ? row.comp0 : row.comp1;
            if (code >= writer_tag.size()) begin
                errors++;
                $display("row %0d completes a dispatch that was never tagged", row_idx);
            end else if (code >= 0) begin
                comp[l].valid = 1'b1;
                comp[l].tag   = writer_tag[code];
            end else if (code == RAND) begin
                pick_outstanding(comp[l].valid, comp[l].tag);
            end
        end
        dispatch = row.slots;
        complete = comp;
        #1;

        // retirement runs from the oldest while entries are complete
        nret = 0;
        while (nret < N && nret < rob_q.size() && rob_q[nret].complete) begin
            nret++;
        end
        room = ROB_DEPTH - rob_q.size() + nret;
        acc  = 0;
        for (int k = N; k >= 1; k--) begin
            if (acc == 0 && prefix_fits(row.slots, k, room)) begin
                acc = k;
            end
        end
        compare_field("accept_count", 32'(accept_count), 32'(acc));
        compare_field("retire_count", 32'(retire_count), 32'(nret));
        compare_field("open_entries", 32'(open_entries), 32'(room));
        if (row.exp_accept != SKIP) begin
            compare_field("accept_count vs table", 32'(accept_count), 32'(row.exp_accept));
        end
        if (row.exp_retire != SKIP) begin
            compare_field("retire_count vs table", 32'(retire_count), 32'(row.exp_retire));
        end
        for (int i = 0; i < N; i++) begin
            compare_field($sformatf("retire[%0d].valid", i), 32'(retire[i].valid), 32'(i < nret));
            if (i < nret) begin
                compare_field($sformatf("retire[%0d].has_dest", i),
                              32'(retire[i].has_dest), 32'(rob_q[i].has_dest));
            end
            if (i < nret && rob_q[i].has_dest) begin
                compare_field($sformatf("retire[%0d].arch_dest", i),
                              32'(retire[i].arch_dest), 32'(rob_q[i].arch_dest));
                compare_field($sformatf("retire[%0d].t", i), 32'(retire[i].t), 32'(rob_q[i].t));
                compare_field($sformatf("retire[%0d].told", i),
                              32'(retire[i].told), 32'(rob_q[i].told));
            end
        end

        // state after the edge, completions see only entries already held
        for (int l = 0; l < N; l++) begin
            for (int k = 0; k < rob_q.size(); k++) begin
                entry = rob_q[k];
                if (comp[l].valid && entry.has_dest && entry.t == comp[l].tag) begin
                    entry.complete = 1'b1;
                    rob_q[k]       = entry;
                end
            end
        end
        repeat (nret) begin
            entry = rob_q.pop_front();
            if (entry.has_dest) begin
                reclaim.push_back(entry.told);
            end
        end
        for (int i = 0; i < acc; i++) begin
            entry           = '0;
            entry.arch_dest = row.slots[i].arch_dest;
            if (writes_dest(row.slots[i])) begin
                entry.has_dest = 1'b1;
                entry.t        = free_q.pop_front();
                entry.told     = map_q[entry.arch_dest];
                map_q[entry.arch_dest] = entry.t;
                writer_tag.push_back(entry.t);
                compare_field($sformatf("dispatch_tag[%0d]", i), 32'(dispatch_tag[i]),
                              32'(entry.t));
            end else begin
                entry.complete = 1'b1;
            end
            rob_q.push_back(entry);
        end
        // reclaimed tags join the queue behind this cycle's pops
        foreach (reclaim[j]) begin
            free_q.push_back(reclaim[j]);
        end
    endtask

    initial begin
        #((RESET_CYCLES + NUM_ROWS + 20) * PERIOD);
        $display("watchdog expired before the stimulus table finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        build_table();
        for (int r = 0; r < rob_pkg::ARCH_REGS; r++) begin
            map_q[r] = rob_pkg::phys_tag_t'(r);
        end
        for (int t = rob_pkg::ARCH_REGS; t < rob_pkg::PHYS_REGS; t++) begin
            free_q.push_back(rob_pkg::phys_tag_t'(t));
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (table_q[r]) begin
            row_idx = r;
            apply_row(table_q[r]);
            @(negedge clock);
        end

        row_idx  = NUM_ROWS;
        dispatch = '0;
        complete = '0;
        #1;
        compare_field("open_entries after drain", 32'(open_entries), 32'(ROB_DEPTH));
        assert (rob_q.size() == 0) else begin
            errors++;
            $display("%0d entries still waiting after the drain rows", rob_q.size());
        end
        assert (writer_tag.size() > rob_pkg::FREE_REGS) else begin
            errors++;
            $display("free queue never wrapped onto reclaimed tags");
        end
        // failures of the bound ROB properties
        assert (dut0.rob0.props0.failures == 0) else begin
            errors += dut0.rob0.props0.failures;
            $display("%0d ROB property failures during the run", dut0.rob0.props0.failures);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
